/* vlog.f */
core_pkg.sv
regs_if.sv
pipe_reg.sv
regfile.sv
operand_forward.sv
alu_unit.sv
branch_unit.sv
exec_backend.sv
tb_exec_backend.sv

/* tb_exec_backend.sv */
module tb_exec_backend;

    localparam int n_alu = 300;
    localparam int n_fwd = 300;
    localparam int n_branch = 200;
    localparam int n_stall = 300;
    localparam int cycle_limit = 40 * (n_alu + n_fwd + n_branch + n_stall) + 200;

    logic clock, reset_n, stall, issue_valid;
    logic src1_is_reg, src2_is_reg, need_to_wb, is_unsigned, is_word, is_imm;
    core_pkg::pc_t issue_pc;
    core_pkg::reg_addr_t rs1, rs2, rd;
    core_pkg::xdata_t src1, src2, imm;
    core_pkg::alu_op_t alu_op;
    core_pkg::cx_type_t cx_type;
    logic redirect_valid, retire_valid, retire_we;
    core_pkg::pc_t redirect_pc, retire_pc;
    core_pkg::reg_addr_t retire_rd;
    core_pkg::xdata_t retire_data;

    logic [31:0] lfsr;
    core_pkg::xdata_t arch [0:31];
    core_pkg::retire_pkt_t ex_m, wb_m, prev_out;
    core_pkg::pc_t redirect_to, fe_pc;
    logic redirect_due, mode_dep, mode_br, mode_stall, draining;
    int cycles, errors, accepted, tests_passed, tests_failed;

    exec_backend dut_i (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit.
    function automatic logic [63:0] draw(input int nbits);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic core_pkg::xdata_t ref_alu(input core_pkg::alu_op_t op, input logic word,
                                                 input core_pkg::xdata_t a,
                                                 input core_pkg::xdata_t b);
        core_pkg::xdata_t x;
        core_pkg::xdata_t y;
        core_pkg::xdata_t r;
        logic [5:0]       sh;
        x = a;
        y = b;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        // word forms widen the low halves by the signedness the op needs.
        if (word && (op == core_pkg::alu_sltu || op == core_pkg::alu_srl)) begin
            x = {32'd0, a[31:0]};
            y = {32'd0, b[31:0]};
        end else if (word) begin
            x = {{32{a[31]}}, a[31:0]};
            y = {{32{b[31]}}, b[31:0]};
        end
        case (op)
            core_pkg::alu_add:    r = x + y;
            core_pkg::alu_sub:    r = x - y;
            core_pkg::alu_sll:    r = x << sh;
            core_pkg::alu_slt:    r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
            core_pkg::alu_sltu:   r = (x < y) ? 64'd1 : 64'd0;
            core_pkg::alu_xor:    r = x ^ y;
            core_pkg::alu_srl:    r = x >> sh;
            core_pkg::alu_sra:    r = $signed(x) >>> sh;
            core_pkg::alu_or:     r = x | y;
            core_pkg::alu_and:    r = x & y;
            core_pkg::alu_pass_b: r = y;
            default:              r = '0;
        endcase
        return word ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic logic ref_taken(input core_pkg::cx_type_t cx, input logic uns,
                                       input core_pkg::xdata_t a, input core_pkg::xdata_t b);
        logic lt;
        lt = uns ? (a < b) : ($signed(a) < $signed(b));
        case (cx)
            core_pkg::cx_jal, core_pkg::cx_jalr: return 1'b1;
            core_pkg::cx_beq: return a == b;
            core_pkg::cx_bne: return a != b;
            core_pkg::cx_blt: return lt;
            core_pkg::cx_bge: return !lt;
            default:          return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic gen_instr();
        logic [63:0] r;
        r = draw(22);
        issue_valid = !draining && (r[1:0] != 2'd0);
        issue_pc = fe_pc;
        rs1 = {2'b00, r[4:2]};
        rs2 = {2'b00, r[7:5]};
        // without dependences rd is x0 or one of x8..x15, never a source.
        rd = mode_dep ? {2'b00, r[10:8]} : ((r[12:11] == 2'd0) ? 5'd0 : {2'b01, r[10:8]});
        src1_is_reg = r[13];
        src2_is_reg = r[14];
        is_word = r[15];
        is_imm = r[16];
        is_unsigned = r[17];
        alu_op = core_pkg::alu_op_t'(draw(4) % 11);
        cx_type = mode_br ? core_pkg::cx_type_t'(draw(3) % 7) : core_pkg::cx_none;
        need_to_wb = (r[20:18] != 3'd0) && (cx_type < core_pkg::cx_beq);
        src1 = draw(64);
        src2 = r[21] ? src1 : draw(64);
        imm = draw(64);
    endtask

    task automatic step();
        logic             held;
        logic             exp_redirect;
        core_pkg::xdata_t a;
        core_pkg::xdata_t b;
        core_pkg::xdata_t res;
        @(negedge clock);
        held = stall;
        if (!held) begin
            gen_instr();
        end
        stall = mode_stall && (draw(2) == 64'd0);
        #1;
        exp_redirect = redirect_due && !stall;
        check_value("redirect_valid", redirect_valid, exp_redirect);
        if (exp_redirect) begin
            check_value("redirect_pc", redirect_pc, redirect_to);
        end
        if (held) begin
            check_value("retire_valid (held)", retire_valid, prev_out.valid);
            check_value("retire_pc (held)", retire_pc, prev_out.pc);
            check_value("retire_rd (held)", retire_rd, prev_out.rd);
            check_value("retire_we (held)", retire_we, prev_out.need_to_wb);
            check_value("retire_data (held)", retire_data, prev_out.result);
        end
        check_value("retire_valid", retire_valid, wb_m.valid);
        check_value("retire_we", retire_we, wb_m.valid && wb_m.need_to_wb && (wb_m.rd != 0));
        if (wb_m.valid) begin
            check_value("retire_pc", retire_pc, wb_m.pc);
            check_value("retire_rd", retire_rd, wb_m.rd);
            check_value("retire_data", retire_data, wb_m.result);
        end
        prev_out = '{retire_valid, retire_pc, retire_rd, retire_we, retire_data};
        if (!stall) begin
            wb_m = ex_m;
            ex_m = '0;
            if (exp_redirect) begin
                redirect_due = 1'b0;
                fe_pc = redirect_to;
            end else if (issue_valid) begin
                a = src1_is_reg ? arch[rs1] : src1;
                b = src2_is_reg ? arch[rs2] : src2;
                if (cx_type == core_pkg::cx_jal || cx_type == core_pkg::cx_jalr) begin
                    res = issue_pc + 64'd4;
                end else begin
                    res = ref_alu(alu_op, is_word, a, is_imm ? imm : b);
                end
                ex_m = '{1'b1, issue_pc, rd, need_to_wb, res};
                if (need_to_wb && rd != 5'd0) begin
                    arch[rd] = res;
                end
                redirect_due = ref_taken(cx_type, is_unsigned, a, b);
                redirect_to = (cx_type == core_pkg::cx_jalr) ? ((a + imm) & ~64'd1)
                                                             : issue_pc + imm;
                fe_pc = issue_pc + 64'd4;
                accepted++;
            end
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        if (errors == start_err) begin
            tests_passed++;
            $display("test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - start_err);
        end
    endtask

    task automatic run_test(input string name, input int n, input logic dep,
                            input logic br, input logic stl);
        int start_err;
        int start_acc;
        start_err = errors;
        start_acc = accepted;
        mode_dep = dep;
        mode_br = br;
        mode_stall = stl;
        draining = 1'b0;
        while (accepted - start_acc < n) begin
            step();
        end
        // let the last instructions retire before the next test.
        draining = 1'b1;
        mode_stall = 1'b0;
        repeat (5) step();
        report_test(name, start_err);
    endtask

    initial begin
        {stall, issue_valid, src1_is_reg, src2_is_reg, need_to_wb} = '0;
        {is_unsigned, is_word, is_imm, rs1, rs2, rd} = '0;
        {issue_pc, src1, src2, imm} = '0;
        alu_op = core_pkg::alu_add;
        cx_type = core_pkg::cx_none;
        reset_n = 1'b0;
        lfsr = 32'h49caeab9;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        {ex_m, wb_m, prev_out} = '0;
        {redirect_due, redirect_to, fe_pc} = '0;
        {cycles, errors, accepted, tests_passed, tests_failed} = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        repeat (3) begin
            @(negedge clock);
            #1;
            check_value("retire_valid", retire_valid, 1'b0);
            check_value("retire_we", retire_we, 1'b0);
            check_value("redirect_valid", redirect_valid, 1'b0);
        end
        report_test("reset", 0);
        run_test("alu_independent", n_alu, 1'b0, 1'b0, 1'b0);
        run_test("forwarding", n_fwd, 1'b1, 1'b0, 1'b0);
        run_test("branch_jump", n_branch, 1'b1, 1'b1, 1'b0);
        run_test("random_stall", n_stall, 1'b1, 1'b1, 1'b1);
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* exec_backend.sv */
module exec_backend (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                stall,

    input  logic                issue_valid,
    input  core_pkg::pc_t       issue_pc,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  logic                src1_is_reg,
    input  logic                src2_is_reg,
    input  core_pkg::xdata_t    src1,
    input  core_pkg::xdata_t    src2,
    input  core_pkg::xdata_t    imm,
    input  logic                need_to_wb,
    input  core_pkg::alu_op_t   alu_op,
    input  core_pkg::cx_type_t  cx_type,
    input  logic                is_unsigned,
    input  logic                is_word,
    input  logic                is_imm,

    output logic                redirect_valid,
    output core_pkg::pc_t       redirect_pc,

    output logic                retire_valid,
    output core_pkg::pc_t       retire_pc,
    output core_pkg::reg_addr_t retire_rd,
    output logic                retire_we,
    output core_pkg::xdata_t    retire_data
);

    regs_if rf_if ();

    core_pkg::issue_pkt_t  issue_pkt;
    core_pkg::issue_pkt_t  ex_pkt;
    core_pkg::retire_pkt_t retire_pkt;
    core_pkg::retire_pkt_t wb_pkt;
    core_pkg::xdata_t      opnd1;
    core_pkg::xdata_t      opnd2;
    core_pkg::xdata_t      alu_result;
    core_pkg::xdata_t      link;
    core_pkg::xdata_t      ex_result;
    core_pkg::pc_t         target;
    logic                  taken;
    logic                  ex_is_jump;

    operand_forward operand_forward_i (
        .rd_port     (rf_if.reader),
        .rs1         (rs1),
        .rs2         (rs2),
        .src1_is_reg (src1_is_reg),
        .src2_is_reg (src2_is_reg),
        .src1        (src1),
        .src2        (src2),
        .ex_pkt      (ex_pkt),
        .ex_result   (ex_result),
        .wb_pkt      (wb_pkt),
        .opnd1       (opnd1),
        .opnd2       (opnd2)
    );

    regfile regfile_i (
        .clock   (clock),
        .reset_n (reset_n),
        .rd_port (rf_if.file),
        .we      (retire_we),
        .waddr   (wb_pkt.rd),
        .wdata   (wb_pkt.result)
    );

    always_comb begin
        issue_pkt.valid       = issue_valid;
        issue_pkt.pc          = issue_pc;
        issue_pkt.rd          = rd;
        issue_pkt.need_to_wb  = need_to_wb;
        issue_pkt.alu_op      = alu_op;
        issue_pkt.cx_type     = cx_type;
        issue_pkt.is_unsigned = is_unsigned;
        issue_pkt.is_word     = is_word;
        issue_pkt.is_imm      = is_imm;
        issue_pkt.imm         = imm;
        issue_pkt.opnd1       = opnd1;
        issue_pkt.opnd2       = opnd2;
    end

    // a taken transfer in execute kills the instruction now at issue.
    pipe_reg #(
        .payload_t (core_pkg::issue_pkt_t)
    ) ex_stage_i (
        .clock   (clock),
        .reset_n (reset_n),
        .stall   (stall),
        .flush   (redirect_valid),
        .d       (issue_pkt),
        .q       (ex_pkt)
    );

    alu_unit alu_unit_i (
        .alu_op  (ex_pkt.alu_op),
        .is_word (ex_pkt.is_word),
        .is_imm  (ex_pkt.is_imm),
        .opnd1   (ex_pkt.opnd1),
        .opnd2   (ex_pkt.opnd2),
        .imm     (ex_pkt.imm),
        .result  (alu_result)
    );

    branch_unit branch_unit_i (
        .cx_type     (ex_pkt.cx_type),
        .is_unsigned (ex_pkt.is_unsigned),
        .pc          (ex_pkt.pc),
        .opnd1       (ex_pkt.opnd1),
        .opnd2       (ex_pkt.opnd2),
        .imm         (ex_pkt.imm),
        .taken       (taken),
        .target      (target),
        .link        (link)
    );

    assign ex_is_jump     = (ex_pkt.cx_type == core_pkg::cx_jal) ||
                            (ex_pkt.cx_type == core_pkg::cx_jalr);
    assign ex_result      = ex_is_jump ? link : alu_result;
    assign redirect_valid = ex_pkt.valid && taken && !stall;
    assign redirect_pc    = target;

    always_comb begin
        retire_pkt.valid      = ex_pkt.valid;
        retire_pkt.pc         = ex_pkt.pc;
        retire_pkt.rd         = ex_pkt.rd;
        retire_pkt.need_to_wb = ex_pkt.need_to_wb;
        retire_pkt.result     = ex_result;
    end

    pipe_reg #(
        .payload_t (core_pkg::retire_pkt_t)
    ) wb_stage_i (
        .clock   (clock),
        .reset_n (reset_n),
        .stall   (stall),
        .flush   (1'b0),
        .d       (retire_pkt),
        .q       (wb_pkt)
    );

    assign retire_valid = wb_pkt.valid;
    assign retire_pc    = wb_pkt.pc;
    assign retire_rd    = wb_pkt.rd;
    assign retire_data  = wb_pkt.result;
    assign retire_we    = wb_pkt.valid && wb_pkt.need_to_wb && (wb_pkt.rd != 5'd0);

endmodule

/* branch_unit.sv */
module branch_unit (
    input  core_pkg::cx_type_t cx_type,
    input  logic               is_unsigned,
    input  core_pkg::pc_t      pc,
    input  core_pkg::xdata_t   opnd1,
    input  core_pkg::xdata_t   opnd2,
    input  core_pkg::xdata_t   imm,
    output logic               taken,
    output core_pkg::pc_t      target,
    output core_pkg::xdata_t   link
);

    logic             eq;
    logic             lt;
    core_pkg::xdata_t jalr_sum;

    assign eq = (opnd1 == opnd2);
    assign lt = is_unsigned ? (opnd1 < opnd2) : ($signed(opnd1) < $signed(opnd2));

    always_comb begin
        case (cx_type)
            core_pkg::cx_jal:  taken = 1'b1;
            core_pkg::cx_jalr: taken = 1'b1;
            core_pkg::cx_beq:  taken = eq;
            core_pkg::cx_bne:  taken = !eq;
            core_pkg::cx_blt:  taken = lt;
            core_pkg::cx_bge:  taken = !lt;
            default:           taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the computed address.
    assign jalr_sum = opnd1 + imm;

    always_comb begin
        if (cx_type == core_pkg::cx_jalr) begin
            target = {jalr_sum[63:1], 1'b0};
        end else begin
            target = pc + imm;
        end
    end

    assign link = pc + 64'd4;

endmodule

/* alu_unit.sv */
module alu_unit (
    input  core_pkg::alu_op_t alu_op,
    input  logic              is_word,
    input  logic              is_imm,
    input  core_pkg::xdata_t  opnd1,
    input  core_pkg::xdata_t  opnd2,
    input  core_pkg::xdata_t  imm,
    output core_pkg::xdata_t  result
);

    core_pkg::xdata_t b;
    core_pkg::xdata_t res64;
    logic [31:0]      a32;
    logic [31:0]      b32;
    logic [31:0]      res32;
    logic [5:0]       shamt;
    logic [4:0]       shamt_w;

    assign b       = is_imm ? imm : opnd2;
    assign a32     = opnd1[31:0];
    assign b32     = b[31:0];
    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];

    always_comb begin
        case (alu_op)
            core_pkg::alu_add:    res64 = opnd1 + b;
            core_pkg::alu_sub:    res64 = opnd1 - b;
            core_pkg::alu_sll:    res64 = opnd1 << shamt;
            core_pkg::alu_slt:    res64 = {63'd0, $signed(opnd1) < $signed(b)};
            core_pkg::alu_sltu:   res64 = {63'd0, opnd1 < b};
            core_pkg::alu_xor:    res64 = opnd1 ^ b;
            core_pkg::alu_srl:    res64 = opnd1 >> shamt;
            core_pkg::alu_sra:    res64 = $signed(opnd1) >>> shamt;
            core_pkg::alu_or:     res64 = opnd1 | b;
            core_pkg::alu_and:    res64 = opnd1 & b;
            core_pkg::alu_pass_b: res64 = b;
            default:              res64 = '0;
        endcase
    end

    // word forms work on the low half with 5-bit shift amounts.
    always_comb begin
        case (alu_op)
            core_pkg::alu_add:    res32 = a32 + b32;
            core_pkg::alu_sub:    res32 = a32 - b32;
            core_pkg::alu_sll:    res32 = a32 << shamt_w;
            core_pkg::alu_slt:    res32 = {31'd0, $signed(a32) < $signed(b32)};
            core_pkg::alu_sltu:   res32 = {31'd0, a32 < b32};
            core_pkg::alu_xor:    res32 = a32 ^ b32;
            core_pkg::alu_srl:    res32 = a32 >> shamt_w;
            core_pkg::alu_sra:    res32 = $signed(a32) >>> shamt_w;
            core_pkg::alu_or:     res32 = a32 | b32;
            core_pkg::alu_and:    res32 = a32 & b32;
            core_pkg::alu_pass_b: res32 = b32;
            default:              res32 = '0;
        endcase
    end

    // sign-extend bit 31 for word results.
    assign result = is_word ? {{32{res32[31]}}, res32} : res64;

endmodule

/* operand_forward.sv */
module operand_forward (
    regs_if.reader                rd_port,
    input  core_pkg::reg_addr_t   rs1,
    input  core_pkg::reg_addr_t   rs2,
    input  logic                  src1_is_reg,
    input  logic                  src2_is_reg,
    input  core_pkg::xdata_t      src1,
    input  core_pkg::xdata_t      src2,
    input  core_pkg::issue_pkt_t  ex_pkt,
    input  core_pkg::xdata_t      ex_result,
    input  core_pkg::retire_pkt_t wb_pkt,
    output core_pkg::xdata_t      opnd1,
    output core_pkg::xdata_t      opnd2
);

    logic ex_fwd;
    logic wb_fwd;

    assign rd_port.rs1 = rs1;
    assign rd_port.rs2 = rs2;

    // a stage can only forward if it really writes a non-zero register.
    assign ex_fwd = ex_pkt.valid && ex_pkt.need_to_wb && (ex_pkt.rd != 5'd0);
    assign wb_fwd = wb_pkt.valid && wb_pkt.need_to_wb && (wb_pkt.rd != 5'd0);

    // the younger producer in execute wins over write-back.
    always_comb begin
        if (!src1_is_reg) begin
            opnd1 = src1;
        end else if (ex_fwd && (ex_pkt.rd == rs1)) begin
            opnd1 = ex_result;
        end else if (wb_fwd && (wb_pkt.rd == rs1)) begin
            opnd1 = wb_pkt.result;
        end else begin
            opnd1 = rd_port.rdata1;
        end
    end

    always_comb begin
        if (!src2_is_reg) begin
            opnd2 = src2;
        end else if (ex_fwd && (ex_pkt.rd == rs2)) begin
            opnd2 = ex_result;
        end else if (wb_fwd && (wb_pkt.rd == rs2)) begin
            opnd2 = wb_pkt.result;
        end else begin
            opnd2 = rd_port.rdata2;
        end
    end

endmodule

/* regfile.sv */
module regfile (
    input  logic                clock,
    input  logic                reset_n,
    regs_if.file                rd_port,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::xdata_t    wdata
);

    core_pkg::xdata_t regs [1:31];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired to zero.
    always_comb begin
        if (rd_port.rs1 == 5'd0) begin
            rd_port.rdata1 = '0;
        end else begin
            rd_port.rdata1 = regs[rd_port.rs1];
        end
    end

    always_comb begin
        if (rd_port.rs2 == 5'd0) begin
            rd_port.rdata2 = '0;
        end else begin
            rd_port.rdata2 = regs[rd_port.rs2];
        end
    end

endmodule

/* pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // a flush only takes effect on a cycle that advances.
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

/* regs_if.sv */
interface regs_if;

    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::xdata_t    rdata1;
    core_pkg::xdata_t    rdata2;

    // issue side, drives the read addresses.
    modport reader (
        output rs1,
        output rs2,
        input  rdata1,
        input  rdata2
    );

    // register file side, returns data in the same cycle.
    modport file (
        input  rs1,
        input  rs2,
        output rdata1,
        output rdata2
    );

endinterface

/* core_pkg.sv */
package core_pkg;

    localparam int xlen = 64;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] xdata_t;
    typedef logic [xlen-1:0] pc_t;

    // alu operation select, lui uses alu_pass_b.
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

    // control transfer type, blt and bge take is_unsigned for bltu and bgeu.
    typedef enum logic [2:0] {
        cx_none = 3'd0,
        cx_jal  = 3'd1,
        cx_jalr = 3'd2,
        cx_beq  = 3'd3,
        cx_bne  = 3'd4,
        cx_blt  = 3'd5,
        cx_bge  = 3'd6
    } cx_type_t;

    // issue to execute, operands are already forwarded.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        reg_addr_t rd;
        logic      need_to_wb;
        alu_op_t   alu_op;
        cx_type_t  cx_type;
        logic      is_unsigned;
        logic      is_word;
        logic      is_imm;
        xdata_t    imm;
        xdata_t    opnd1;
        xdata_t    opnd2;
    } issue_pkt_t;

    // execute to write-back.
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        reg_addr_t rd;
        logic      need_to_wb;
        xdata_t    result;
    } retire_pkt_t;

endpackage
